// ==== gpio_params.svh ====
/* GPIO subsystem parameters */

`ifndef GPIO_PARAMS_SVH
`define GPIO_PARAMS_SVH

////////////////////////////////////////////////////////////
// Pin configuration
////////////////////////////////////////////////////////////

// Number of GPIO pins, at most 32
`define GPIO_NUM_PINS 16

// Cycles between two scanner reads of DAT
`define GPIO_SCAN_PERIOD 16

////////////////////////////////////////////////////////////
// Wishbone bus widths
////////////////////////////////////////////////////////////

// Word address, selects one of four registers
`define WB_ADR_W 2
// Data path and byte selects
`define WB_DAT_W 32
`define WB_SEL_W 4

`endif

// ==== wb_pkg.sv ====
/* Wishbone bus types */

`include "gpio_params.svh"

package wb_pkg;

    // Basic bus field types
    typedef logic [`WB_ADR_W-1:0] wb_adr_t;
    typedef logic [`WB_DAT_W-1:0] wb_dat_t;
    typedef logic [`WB_SEL_W-1:0] wb_sel_t;

    // Master to slave request
    // All fields stay stable from stb until ack
    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_sel_t sel;
        wb_dat_t dat;
    } wb_req_t;

    // Slave to master response
    // Read data is valid while ack is high
    typedef struct packed {
        logic    ack;
        wb_dat_t dat;
    } wb_rsp_t;

endpackage

// ==== gpio_pkg.sv ====
/* GPIO register map and scanner types */

`include "gpio_params.svh"

package gpio_pkg;

    // One bit per GPIO pin
    typedef logic [`GPIO_NUM_PINS-1:0] gpio_pins_t;

    // Word addresses of the register block
    // INC is decoded but has no storage behind it
    typedef enum logic [1:0] {
        REG_DAT = 2'd0,
        REG_TSC = 2'd1,
        REG_INC = 2'd2
    } gpio_reg_e;

    // Scanner FSM
    // WAIT counts the period, REQ holds the bus read,
    // DONE is the release cycle after ack
    typedef enum logic [1:0] {
        WAIT = 2'd0,
        REQ  = 2'd1,
        DONE = 2'd2
    } scan_state_e;

endpackage

// ==== wb_arbiter.sv ====
/* Two-master Wishbone arbiter */

module wb_arbiter (
    input  logic            wb_clk_i,
    input  logic            wb_rst_i,
    // Master 0 is the host port
    input  wb_pkg::wb_req_t m0_req_i,
    output wb_pkg::wb_rsp_t m0_rsp_o,
    // Master 1 is the scanner
    input  wb_pkg::wb_req_t m1_req_i,
    output wb_pkg::wb_rsp_t m1_rsp_o,
    // Shared slave
    output wb_pkg::wb_req_t s_req_o,
    input  wb_pkg::wb_rsp_t s_rsp_i
);

    import wb_pkg::*;

    ////////////////////////////////////////////////////////////
    // Grant state
    ////////////////////////////////////////////////////////////

    // Current owner, 0 for host, 1 for scanner
    logic    owner;
    // Bus is held by the owner
    logic    owner_vld;
    // Request of the current owner
    wb_req_t owner_req;

    // Registered grant
    // Idle bus goes to host first, then scanner
    // Grant is released once the owner drops cyc
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            owner     <= 1'b0;
            owner_vld <= 1'b0;
        end else if (!owner_vld) begin
            if (m0_req_i.cyc) begin
                owner     <= 1'b0;
                owner_vld <= 1'b1;
            end else if (m1_req_i.cyc) begin
                owner     <= 1'b1;
                owner_vld <= 1'b1;
            end
        end else if (!owner_req.cyc) begin
            // Cycle finished, bus goes idle
            owner_vld <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Request path
    ////////////////////////////////////////////////////////////

    assign owner_req = owner ? m1_req_i : m0_req_i;

    // Pass the owner's request through
    // Strobe and cycle are masked while nobody holds the bus
    always_comb begin
        s_req_o     = owner_req;
        s_req_o.cyc = owner_req.cyc & owner_vld;
        s_req_o.stb = owner_req.stb & owner_vld;
    end

    ////////////////////////////////////////////////////////////
    // Response path
    ////////////////////////////////////////////////////////////

    // Data goes to both masters
    // Ack only to the owner, the other one keeps waiting
    always_comb begin
        m0_rsp_o.dat = s_rsp_i.dat;
        m0_rsp_o.ack = s_rsp_i.ack & owner_vld & ~owner;
        m1_rsp_o.dat = s_rsp_i.dat;
        m1_rsp_o.ack = s_rsp_i.ack & owner_vld & owner;
    end

endmodule

// ==== wb_gpio.sv ====
/* GPIO register block */

`include "gpio_params.svh"

module wb_gpio (
    input  logic                      wb_clk_i,
    input  logic                      wb_rst_i,
    // Wishbone slave port
    input  wb_pkg::wb_req_t           req_i,
    output wb_pkg::wb_rsp_t           rsp_o,
    // Pins
    input  logic [`GPIO_NUM_PINS-1:0] inp_i,
    output logic [`GPIO_NUM_PINS-1:0] out_o,
    output logic [`GPIO_NUM_PINS-1:0] oe_o
);

    import wb_pkg::*;
    import gpio_pkg::*;

    ////////////////////////////////////////////////////////////
    // Bus handshake
    ////////////////////////////////////////////////////////////

    // Valid access in this cycle
    logic    bus_stb;
    // Registered ack
    logic    ack_q;
    // Per-byte write enables
    wb_sel_t we_byte;
    // Read mux output
    wb_dat_t rd_dat;

    assign bus_stb = req_i.cyc & req_i.stb;

    // One cycle after strobe, one cycle long
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus_stb & ~ack_q;
        end
    end

    assign we_byte = {`WB_SEL_W{req_i.we & bus_stb}} & req_i.sel;

    ////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////

    // Output latch, driven on the pins
    gpio_pins_t gpio_state;
    // Direction, 1 enables the output driver
    gpio_pins_t gpio_dir;

    // Pin i belongs to byte lane i/8
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            gpio_state <= '0;
            gpio_dir   <= '0;
        end else begin
            case (req_i.adr)
                REG_DAT: begin
                    for (int i = 0; i < `GPIO_NUM_PINS; i++) begin
                        if (we_byte[i/8]) gpio_state[i] <= req_i.dat[i];
                    end
                end
                REG_TSC: begin
                    for (int i = 0; i < `GPIO_NUM_PINS; i++) begin
                        if (we_byte[i/8]) gpio_dir[i] <= req_i.dat[i];
                    end
                end
                // INC and the spare address ignore writes
                default: ;
            endcase
        end
    end

    assign out_o = gpio_state;
    assign oe_o  = gpio_dir;

    ////////////////////////////////////////////////////////////
    // Read back
    ////////////////////////////////////////////////////////////

    // DAT returns the live pins, everything else the direction
    always_comb begin
        rd_dat = '0;
        if (req_i.adr == REG_DAT) begin
            rd_dat[`GPIO_NUM_PINS-1:0] = inp_i;
        end else begin
            rd_dat[`GPIO_NUM_PINS-1:0] = gpio_dir;
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rd_dat;

endmodule

// ==== gpio_scanner.sv ====
/* GPIO pin-change scanner */

`include "gpio_params.svh"

module gpio_scanner (
    input  logic                      wb_clk_i,
    input  logic                      wb_rst_i,
    // Wishbone master port
    output wb_pkg::wb_req_t           req_o,
    input  wb_pkg::wb_rsp_t           rsp_i,
    // Change interrupt
    input  logic                      irq_clr_i,
    output logic                      irq_o,
    output logic [`GPIO_NUM_PINS-1:0] chg_mask_o
);

    import gpio_pkg::*;

    // Period counter width, at least one bit
    localparam int CNT_W = (`GPIO_SCAN_PERIOD > 1) ? $clog2(`GPIO_SCAN_PERIOD) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`GPIO_SCAN_PERIOD - 1);

    scan_state_e      state;
    logic [CNT_W-1:0] cnt;
    // First sample after reset has been taken
    logic             base_vld;
    // Read data of the current scan
    gpio_pins_t       sample;
    gpio_pins_t       last_sample;
    gpio_pins_t       diff;
    // Read accepted in this cycle
    logic             scan_ack;
    logic             irq_q;
    gpio_pins_t       chg_mask_q;

    assign scan_ack = (state == REQ) & rsp_i.ack;
    assign sample   = rsp_i.dat[`GPIO_NUM_PINS-1:0];
    assign diff     = sample ^ last_sample;

    ////////////////////////////////////////////////////////////
    // Scan FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state <= WAIT;
            cnt   <= '0;
        end else begin
            case (state)
                WAIT: begin
                    if (cnt == CNT_LAST) begin
                        cnt   <= '0;
                        state <= REQ;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                // Hold the read until the arbiter passes ack
                REQ: if (rsp_i.ack) state <= DONE;
                // cyc and stb are low here
                DONE: state <= WAIT;
                default: state <= WAIT;
            endcase
        end
    end

    // Always a full-word read of DAT
    always_comb begin
        req_o     = '0;
        req_o.cyc = (state == REQ);
        req_o.stb = (state == REQ);
        req_o.adr = REG_DAT;
        req_o.sel = '1;
    end

    ////////////////////////////////////////////////////////////
    // Change detect
    ////////////////////////////////////////////////////////////

    // Previous sample, only meaningful once base_vld is set
    always_ff @(posedge wb_clk_i) begin
        if (scan_ack) last_sample <= sample;
    end

    // A new change wins over a clear in the same cycle
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            base_vld   <= 1'b0;
            irq_q      <= 1'b0;
            chg_mask_q <= '0;
        end else begin
            if (scan_ack) base_vld <= 1'b1;
            if (scan_ack && base_vld && (diff != '0)) begin
                irq_q      <= 1'b1;
                chg_mask_q <= diff;
            end else if (irq_clr_i) begin
                irq_q <= 1'b0;
            end
        end
    end

    assign irq_o      = irq_q;
    assign chg_mask_o = chg_mask_q;

endmodule

// ==== gpio_subsys.sv ====
/* GPIO subsystem top level */

`include "gpio_params.svh"

module gpio_subsys (
    input  logic                      wb_clk_i,
    input  logic                      wb_rst_i,
    // External host port
    input  wb_pkg::wb_req_t           host_req_i,
    output wb_pkg::wb_rsp_t           host_rsp_o,
    // Pins
    input  logic [`GPIO_NUM_PINS-1:0] inp_i,
    output logic [`GPIO_NUM_PINS-1:0] out_o,
    output logic [`GPIO_NUM_PINS-1:0] oe_o,
    // Pin-change interrupt
    input  logic                      irq_clr_i,
    output logic                      irq_o,
    output logic [`GPIO_NUM_PINS-1:0] chg_mask_o
);

    import wb_pkg::*;

    // Scanner master side
    wb_req_t scan_req;
    wb_rsp_t scan_rsp;
    // Arbiter to register block
    wb_req_t gpio_req;
    wb_rsp_t gpio_rsp;

    ////////////////////////////////////////////////////////////
    // Bus arbitration, host has priority
    ////////////////////////////////////////////////////////////

    wb_arbiter wb_arbiter_i (
        .wb_clk_i (wb_clk_i),
        .wb_rst_i (wb_rst_i),
        .m0_req_i (host_req_i),
        .m0_rsp_o (host_rsp_o),
        .m1_req_i (scan_req),
        .m1_rsp_o (scan_rsp),
        .s_req_o  (gpio_req),
        .s_rsp_i  (gpio_rsp)
    );

    // Register block
    wb_gpio wb_gpio_i (
        .wb_clk_i (wb_clk_i),
        .wb_rst_i (wb_rst_i),
        .req_i    (gpio_req),
        .rsp_o    (gpio_rsp),
        .inp_i    (inp_i),
        .out_o    (out_o),
        .oe_o     (oe_o)
    );

    // Periodic reader of DAT
    gpio_scanner gpio_scanner_i (
        .wb_clk_i   (wb_clk_i),
        .wb_rst_i   (wb_rst_i),
        .req_o      (scan_req),
        .rsp_i      (scan_rsp),
        .irq_clr_i  (irq_clr_i),
        .irq_o      (irq_o),
        .chg_mask_o (chg_mask_o)
    );

endmodule

// ==== gpio_subsys_checker.sv ====
/* Wishbone ack and grant checks */

module gpio_subsys_checker (
    input logic clk_i,
    input logic rst_i,
    // Request side as seen by the slave
    input logic cyc_i,
    input logic stb_i,
    // Slave ack
    input logic ack_i,
    // Arbiter grant, tied low where there is none
    input logic grant_vld_i,
    input logic grant_i
);

    ////////////////////////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////////////////////////

    // Ack is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
        ack_i |=> !ack_i)
        else $error("ack stayed high for two cycles");

    // No ack without a strobe in the cycle before
    ack_after_stb: assert property (@(posedge clk_i) disable iff (rst_i)
        ack_i |-> $past(cyc_i && stb_i))
        else $error("ack without a preceding strobe");

    ////////////////////////////////////////////////////////////
    // Arbitration
    ////////////////////////////////////////////////////////////

    // Owner may only switch from an idle bus
    grant_on_idle: assert property (@(posedge clk_i) disable iff (rst_i)
        (grant_i != $past(grant_i)) |-> !$past(grant_vld_i))
        else $error("grant switched while the bus was held");

endmodule

// Slave side of the register block
bind wb_gpio gpio_subsys_checker gpio_chk_i (
    .clk_i       (wb_clk_i),
    .rst_i       (wb_rst_i),
    .cyc_i       (req_i.cyc),
    .stb_i       (req_i.stb),
    .ack_i       (rsp_o.ack),
    .grant_vld_i (1'b0),
    .grant_i     (1'b0)
);

// Slave port and grant of the arbiter
bind wb_arbiter gpio_subsys_checker arb_chk_i (
    .clk_i       (wb_clk_i),
    .rst_i       (wb_rst_i),
    .cyc_i       (s_req_o.cyc),
    .stb_i       (s_req_o.stb),
    .ack_i       (s_rsp_i.ack),
    .grant_vld_i (owner_vld),
    .grant_i     (owner)
);

// ==== gpio_subsys_tb.sv ====
/* GPIO subsystem testbench */

`include "gpio_params.svh"

module gpio_subsys_tb;

    import wb_pkg::*;
    import gpio_pkg::*;

    localparam int NUM_TESTS   = 6;
    localparam int WD_CYCLES   = NUM_TESTS * (4 * `GPIO_SCAN_PERIOD + 200);
    localparam int ACK_TIMEOUT = 4 * `GPIO_SCAN_PERIOD;
    // Covers three complete scan rounds including bus cycles
    localparam int SCAN_WAIT   = 3 * (`GPIO_SCAN_PERIOD + 4);

    logic       wb_clk_i;
    logic       wb_rst_i;
    wb_req_t    host_req_i;
    wb_rsp_t    host_rsp_o;
    gpio_pins_t inp_i;
    gpio_pins_t out_o;
    gpio_pins_t oe_o;
    logic       irq_clr_i;
    logic       irq_o;
    gpio_pins_t chg_mask_o;

    // Run statistics
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    logic [31:0] rng = 32'hfd4d;
    // Expected register contents
    gpio_pins_t  dat_model;
    gpio_pins_t  tsc_model;

    gpio_subsys gpio_subsys_i (
        .wb_clk_i   (wb_clk_i),
        .wb_rst_i   (wb_rst_i),
        .host_req_i (host_req_i),
        .host_rsp_o (host_rsp_o),
        .inp_i      (inp_i),
        .out_o      (out_o),
        .oe_o       (oe_o),
        .irq_clr_i  (irq_clr_i),
        .irq_o      (irq_o),
        .chg_mask_o (chg_mask_o)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #5 wb_clk_i = ~wb_clk_i;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] zero_ext(input gpio_pins_t p);
        logic [31:0] r;
        r = '0;
        r[`GPIO_NUM_PINS-1:0] = p;
        return r;
    endfunction

    // Old value with the selected byte lanes replaced
    function automatic gpio_pins_t merge_bytes(input gpio_pins_t old_v,
                                               input gpio_pins_t new_v,
                                               input logic [3:0] sel);
        logic [31:0] m;
        m = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old_v & ~m[`GPIO_NUM_PINS-1:0]) | (new_v & m[`GPIO_NUM_PINS-1:0]);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        tests_run++;
        if (errors == errs_at_start) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errs_at_start);
        end
    endtask

    // Returns on the falling edge where ack is seen
    task automatic wait_host_ack(output logic acked);
        int n;
        acked = 1'b0;
        n = 0;
        while (!acked && n < ACK_TIMEOUT) begin
            @(negedge wb_clk_i);
            if (host_rsp_o.ack) acked = 1'b1;
            n++;
        end
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [3:0] sel,
                            input logic [31:0] dat);
        logic acked;
        @(negedge wb_clk_i);
        host_req_i.cyc = 1'b1;
        host_req_i.stb = 1'b1;
        host_req_i.we  = 1'b1;
        host_req_i.adr = adr;
        host_req_i.sel = sel;
        host_req_i.dat = dat;
        wait_host_ack(acked);
        if (!acked) begin
            errors++;
            $display("write to address %0d got no ack in %0d cycles", adr, ACK_TIMEOUT);
        end
        // Cycle after ack, release the bus
        host_req_i = '0;
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [31:0] dat);
        logic acked;
        @(negedge wb_clk_i);
        host_req_i.cyc = 1'b1;
        host_req_i.stb = 1'b1;
        host_req_i.we  = 1'b0;
        host_req_i.adr = adr;
        host_req_i.sel = 4'hf;
        host_req_i.dat = '0;
        wait_host_ack(acked);
        dat = host_rsp_o.dat;
        if (!acked) begin
            errors++;
            $display("read from address %0d got no ack in %0d cycles", adr, ACK_TIMEOUT);
        end
        host_req_i = '0;
    endtask

    task automatic pulse_irq_clr();
        @(negedge wb_clk_i);
        irq_clr_i = 1'b1;
        @(negedge wb_clk_i);
        irq_clr_i = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic reset_state();
        int          e0;
        logic [31:0] rd;
        e0 = errors;
        check_value("out_o", zero_ext(out_o), 32'h0);
        check_value("oe_o", zero_ext(oe_o), 32'h0);
        check_value("irq_o", {31'b0, irq_o}, 32'h0);
        wb_read(REG_TSC, rd);
        check_value("tsc", rd, 32'h0);
        dat_model = '0;
        tsc_model = '0;
        report_test("reset_state", e0);
    endtask

    task automatic full_word_writes();
        int          e0;
        logic [31:0] rd;
        e0 = errors;
        rng = xorshift32(rng);
        wb_write(REG_DAT, 4'hf, rng);
        dat_model = rng[`GPIO_NUM_PINS-1:0];
        check_value("out_o", zero_ext(out_o), zero_ext(dat_model));
        rng = xorshift32(rng);
        wb_write(REG_TSC, 4'hf, rng);
        tsc_model = rng[`GPIO_NUM_PINS-1:0];
        check_value("oe_o", zero_ext(oe_o), zero_ext(tsc_model));
        wb_read(REG_TSC, rd);
        check_value("tsc", rd, zero_ext(tsc_model));
        report_test("full_word_writes", e0);
    endtask

    task automatic byte_select_writes();
        int          e0;
        logic [3:0]  sels [4];
        logic [31:0] rd;
        e0 = errors;
        sels = '{4'b0001, 4'b0010, 4'b0000, 4'b1110};
        for (int k = 0; k < 4; k++) begin
            rng = xorshift32(rng);
            wb_write(REG_DAT, sels[k], rng);
            dat_model = merge_bytes(dat_model, rng[`GPIO_NUM_PINS-1:0], sels[k]);
            check_value("out_o", zero_ext(out_o), zero_ext(dat_model));
            rng = xorshift32(rng);
            wb_write(REG_TSC, sels[k], rng);
            tsc_model = merge_bytes(tsc_model, rng[`GPIO_NUM_PINS-1:0], sels[k]);
            check_value("oe_o", zero_ext(oe_o), zero_ext(tsc_model));
            wb_read(REG_TSC, rd);
            check_value("tsc", rd, zero_ext(tsc_model));
        end
        report_test("byte_select_writes", e0);
    endtask

    task automatic input_readback();
        int          e0;
        logic [31:0] rd;
        e0 = errors;
        for (int k = 0; k < 3; k++) begin
            rng = xorshift32(rng);
            @(negedge wb_clk_i);
            inp_i = rng[`GPIO_NUM_PINS-1:0];
            wb_read(REG_DAT, rd);
            check_value("dat", rd, zero_ext(inp_i));
            // Unimplemented addresses mirror TSC
            wb_read(REG_INC, rd);
            check_value("inc", rd, zero_ext(tsc_model));
            wb_read(2'd3, rd);
            check_value("spare", rd, zero_ext(tsc_model));
        end
        report_test("input_readback", e0);
    endtask

    task automatic change_interrupt();
        int         e0;
        gpio_pins_t old_v;
        gpio_pins_t new_v;
        e0 = errors;
        rng = xorshift32(rng);
        old_v = rng[`GPIO_NUM_PINS-1:0];
        rng = xorshift32(rng);
        new_v = rng[`GPIO_NUM_PINS-1:0];
        if (new_v == old_v) new_v[0] = ~new_v[0];
        // Let the scanner settle on the old value as its baseline
        @(negedge wb_clk_i);
        inp_i = old_v;
        repeat (SCAN_WAIT) @(negedge wb_clk_i);
        pulse_irq_clr();
        check_value("irq_o", {31'b0, irq_o}, 32'h0);
        @(negedge wb_clk_i);
        inp_i = new_v;
        repeat (SCAN_WAIT) @(negedge wb_clk_i);
        check_value("irq_o", {31'b0, irq_o}, 32'h1);
        check_value("chg_mask_o", zero_ext(chg_mask_o), zero_ext(old_v ^ new_v));
        pulse_irq_clr();
        check_value("irq_o", {31'b0, irq_o}, 32'h0);
        report_test("change_interrupt", e0);
    endtask

    // Host traffic overlaps the scanner reads
    task automatic reads_during_scans();
        int          e0;
        logic [31:0] rd;
        e0 = errors;
        for (int k = 0; k < 24; k++) begin
            rng = xorshift32(rng);
            @(negedge wb_clk_i);
            inp_i = rng[`GPIO_NUM_PINS-1:0];
            wb_read(REG_DAT, rd);
            check_value("dat", rd, zero_ext(inp_i));
            if (k % 3 == 0) begin
                wb_read(REG_TSC, rd);
                check_value("tsc", rd, zero_ext(tsc_model));
            end
        end
        report_test("reads_during_scans", e0);
    endtask

    ////////////////////////////////////////////////////////////
    // Sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        host_req_i = '0;
        inp_i      = '0;
        irq_clr_i  = 1'b0;
        wb_rst_i   = 1'b1;
        repeat (5) @(posedge wb_clk_i);
        @(negedge wb_clk_i);
        wb_rst_i = 1'b0;
        reset_state();
        full_word_writes();
        byte_select_writes();
        input_readback();
        change_interrupt();
        reads_during_scans();
        $display("%0d tests run, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge wb_clk_i);
        $display("watchdog expired after %0d cycles, run stopped", WD_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+.
wb_pkg.sv
gpio_pkg.sv
wb_arbiter.sv
wb_gpio.sv
gpio_scanner.sv
gpio_subsys.sv
gpio_subsys_checker.sv
gpio_subsys_tb.sv

// ==== Makefile ====
# Verilator build for the GPIO subsystem testbench

SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = gpio_subsys_tb
FILELIST = src.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Result comes from the log, so a missing pass line fails the target
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
